// File: rtl/noc_router_pkg.sv
`default_nettype none

package noc_router_pkg;

    // ======================================================================
    // sizes
    // ======================================================================
    localparam int NUM_PORTS = 5;
    localparam int PORT_W = 3;
    localparam int NUM_VCS = 2;
    localparam int VC_W = 1;
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int COUNT_W = $clog2(FIFO_DEPTH + 1);
    localparam int PKT_LEN_W = 8;
    localparam int ROUTER_FIFO_THIRDS_RD = 3 * FIFO_DEPTH / 4;
    localparam int FLIT_W = 32;
    localparam int STATE_W = 3;

    localparam logic [2:0] ROUTER_X = 3'd2;
    localparam logic [2:0] ROUTER_Y = 3'd2;

    localparam logic [PORT_W-1:0] PORT_LOCAL = 3'd0;
    localparam logic [PORT_W-1:0] PORT_EAST = 3'd1;
    localparam logic [PORT_W-1:0] PORT_WEST = 3'd2;
    localparam logic [PORT_W-1:0] PORT_NORTH = 3'd3;
    localparam logic [PORT_W-1:0] PORT_SOUTH = 3'd4;

    localparam logic [1:0] FLIT_HEAD = 2'b01;
    localparam logic [1:0] FLIT_BODY = 2'b10;

    // input state table steps
    localparam logic [STATE_W-1:0] ST_IDLE = 3'd0;
    localparam logic [STATE_W-1:0] ST_ROUTING = 3'd1;
    localparam logic [STATE_W-1:0] ST_VC_ALLOC = 3'd2;
    localparam logic [STATE_W-1:0] ST_SW_ALLOC = 3'd3;
    localparam logic [STATE_W-1:0] ST_ACTIVE = 3'd4;

    // ======================================================================
    // flit views
    // ======================================================================
    typedef struct packed {
        logic [1:0]           kind;
        logic [2:0]           dest_x;
        logic [2:0]           dest_y;
        logic [PKT_LEN_W-1:0] length;  // flits, head included.
        logic [FLIT_W-17:0]   spare;
    } head_flit_t;

    typedef struct packed {
        logic [1:0]        kind;
        logic [FLIT_W-3:0] payload;
    } body_flit_t;

    typedef union packed {
        head_flit_t head;
        body_flit_t body;
    } flit_u;

    // ======================================================================
    // helpers
    // ======================================================================
    function automatic logic [PORT_W-1:0] xy_route(
        input logic [2:0] dest_x,
        input logic [2:0] dest_y
    );
        if (dest_x > ROUTER_X) begin
            return PORT_EAST;
        end else if (dest_x < ROUTER_X) begin
            return PORT_WEST;
        end else if (dest_y > ROUTER_Y) begin
            return PORT_NORTH;
        end else if (dest_y < ROUTER_Y) begin
            return PORT_SOUTH;
        end
        return PORT_LOCAL;
    endfunction

    function automatic logic [PKT_LEN_W-1:0] packet_length(input flit_u flit);
        return flit.head.length;
    endfunction

    // first requester at or after ptr, wrapping.
    function automatic logic [PORT_W-1:0] rr_pick(
        input logic [NUM_PORTS-1:0] req,
        input logic [PORT_W-1:0]    ptr
    );
        logic [PORT_W-1:0] pick;
        logic [PORT_W-1:0] idx;
        pick = ptr;
        for (int k = NUM_PORTS - 1; k >= 0; k--) begin
            idx = PORT_W'((int'(ptr) + k) % NUM_PORTS);
            if (req[idx]) begin
                pick = idx;
            end
        end
        return pick;
    endfunction

    function automatic logic [PORT_W-1:0] next_port(input logic [PORT_W-1:0] p);
        return (p == PORT_W'(NUM_PORTS - 1)) ? '0 : p + 1'b1;
    endfunction

endpackage

`default_nettype wire

// File: rtl/flit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module flit_fifo
    import noc_router_pkg::*;
(
    input  wire logic         CLK,
    input  wire logic         nRST,
    input  wire logic         wen,
    input  wire logic         ren,
    input  wire flit_u        wdata,
    output flit_u             rdata,
    output logic              empty,
    output logic [COUNT_W-1:0] count,
    output logic              overrun,
    output logic              underrun
);

    flit_u            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             do_write;
    logic             do_read;

    assign full = (count == COUNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign do_write = wen && (!full || ren);  // a read frees the slot.
    assign do_read = ren && !empty;
    assign rdata = mem[rd_ptr];  // front word, no read needed.

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            overrun <= 1'b0;
            underrun <= 1'b0;
        end else begin
            overrun <= wen && full && !ren;
            underrun <= ren && empty;
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + COUNT_W'(do_write) - COUNT_W'(do_read);
        end
    end

    always_ff @(posedge CLK) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: rtl/input_buffers.sv
`timescale 1ns/1ps
`default_nettype none

module input_buffers
    import noc_router_pkg::*;
(
    input  wire logic                              CLK,
    input  wire logic                              nRST,
    input  wire logic  [NUM_PORTS-1:0]             in_wen,
    input  wire flit_u [NUM_PORTS-1:0]             in_flit,
    input  wire logic  [NUM_PORTS-1:0]             fifo_ren,
    output logic       [NUM_PORTS-1:0]             in_available,
    output wire flit_u [NUM_PORTS-1:0]             head_flit,
    output wire logic  [NUM_PORTS-1:0]             fifo_empty,
    output logic       [NUM_PORTS-1:0]             req_routing,
    input  wire logic  [NUM_PORTS-1:0]             routing_granted,
    input  wire logic  [PORT_W-1:0]                routing_outport,
    output logic       [NUM_PORTS-1:0]             req_vc,
    input  wire logic  [NUM_PORTS-1:0]             vc_granted,
    input  wire logic  [NUM_PORTS-1:0][VC_W-1:0]   vc_selection,
    output logic       [NUM_PORTS-1:0]             req_switch,
    input  wire logic  [NUM_PORTS-1:0]             switch_granted,
    output logic       [NUM_PORTS-1:0][PORT_W-1:0] switch_outport,
    output logic       [NUM_PORTS-1:0][VC_W-1:0]   final_vc,
    output logic       [NUM_PORTS-1:0]             req_crossbar
);

    logic [NUM_PORTS-1:0][STATE_W-1:0]   state;
    logic [NUM_PORTS-1:0][PKT_LEN_W-1:0] pkt_len;
    logic [NUM_PORTS-1:0][PKT_LEN_W-1:0] pkt_cnt;
    logic [NUM_PORTS-1:0][COUNT_W-1:0]   rd_cnt;  // reads since last credit.
    logic [NUM_PORTS-1:0]                overrun;
    logic [NUM_PORTS-1:0]                underrun;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
        flit_fifo u_fifo (
            .CLK(CLK),
            .nRST(nRST),
            .wen(in_wen[p]),
            .ren(fifo_ren[p]),
            .wdata(in_flit[p]),
            .rdata(head_flit[p]),
            .empty(fifo_empty[p]),
            .count(),
            .overrun(overrun[p]),
            .underrun(underrun[p])
        );
    end

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            req_routing[p] = (state[p] == ST_ROUTING);
            req_vc[p] = (state[p] == ST_VC_ALLOC);
            req_switch[p] = (state[p] == ST_SW_ALLOC);
            req_crossbar[p] = (state[p] == ST_ACTIVE);
        end
    end

    // ======================================================================
    // per-input state table
    // ======================================================================
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= '0;
            switch_outport <= '0;
            final_vc <= '0;
            pkt_len <= '0;
            pkt_cnt <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                case (state[p])
                    ST_IDLE: begin
                        if (!fifo_empty[p]) begin
                            state[p] <= ST_ROUTING;  // a head waits at the front.
                        end
                    end
                    ST_ROUTING: begin
                        if (routing_granted[p]) begin
                            switch_outport[p] <= routing_outport;
                            state[p] <= ST_VC_ALLOC;
                        end
                    end
                    ST_VC_ALLOC: begin
                        if (vc_granted[p]) begin
                            final_vc[p] <= vc_selection[p];
                            state[p] <= ST_SW_ALLOC;
                        end
                    end
                    ST_SW_ALLOC: begin
                        if (switch_granted[p]) begin
                            pkt_len[p] <= packet_length(head_flit[p]);
                            pkt_cnt[p] <= '0;
                            state[p] <= ST_ACTIVE;
                        end
                    end
                    default: begin  // active.
                        if (fifo_ren[p]) begin
                            pkt_cnt[p] <= pkt_cnt[p] + 1'b1;
                            if (pkt_cnt[p] + 1'b1 == pkt_len[p]) begin
                                state[p] <= ST_IDLE;
                            end
                        end
                    end
                endcase
            end
        end
    end

    // ======================================================================
    // credits to upstream
    // ======================================================================
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rd_cnt <= '0;
            in_available <= '0;
        end else begin
            in_available <= '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (fifo_ren[p]) begin
                    if (rd_cnt[p] == COUNT_W'(ROUTER_FIFO_THIRDS_RD - 1)) begin
                        rd_cnt[p] <= '0;
                        in_available[p] <= 1'b1;
                    end else begin
                        rd_cnt[p] <= rd_cnt[p] + 1'b1;
                    end
                end
            end
        end
    end

    always @(posedge CLK) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (overrun[p]) begin
                $warning("input %0d fifo overrun", p);
            end
            if (underrun[p]) begin
                $warning("input %0d fifo underrun", p);
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/route_compute.sv
`timescale 1ns/1ps
`default_nettype none

module route_compute
    import noc_router_pkg::*;
(
    input  wire logic                  CLK,
    input  wire logic                  nRST,
    input  wire logic  [NUM_PORTS-1:0] req_routing,
    input  wire flit_u [NUM_PORTS-1:0] head_flit,
    output logic       [NUM_PORTS-1:0] routing_granted,
    output logic       [PORT_W-1:0]    routing_outport
);

    logic [NUM_PORTS-1:0] eligible;
    logic [PORT_W-1:0]    rr_ptr;
    logic [PORT_W-1:0]    pick;

    // an input still sees its grant pulse for a cycle.
    assign eligible = req_routing & ~routing_granted;
    assign pick = rr_pick(eligible, rr_ptr);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rr_ptr <= '0;
            routing_granted <= '0;
        end else begin
            routing_granted <= '0;
            if (|eligible) begin
                routing_granted[pick] <= 1'b1;
                rr_ptr <= next_port(pick);
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (|eligible) begin
            routing_outport <= xy_route(head_flit[pick].head.dest_x,
                                        head_flit[pick].head.dest_y);
        end
    end

endmodule

`default_nettype wire

// File: rtl/vc_switch_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module vc_switch_alloc
    import noc_router_pkg::*;
(
    input  wire logic                             CLK,
    input  wire logic                             nRST,
    input  wire logic [NUM_PORTS-1:0]             req_vc,
    input  wire logic [NUM_PORTS-1:0]             req_switch,
    input  wire logic [NUM_PORTS-1:0]             req_crossbar,
    input  wire logic [NUM_PORTS-1:0][PORT_W-1:0] switch_outport,
    output logic      [NUM_PORTS-1:0]             vc_granted,
    output logic      [NUM_PORTS-1:0][VC_W-1:0]   vc_selection,
    output logic      [NUM_PORTS-1:0]             switch_granted,
    output logic      [NUM_PORTS-1:0][PORT_W-1:0] out_owner,
    output logic      [NUM_PORTS-1:0]             out_locked
);

    logic [NUM_PORTS-1:0][NUM_VCS-1:0]   vc_busy;
    logic [NUM_PORTS-1:0][PORT_W-1:0]    vc_ptr;
    logic [NUM_PORTS-1:0][PORT_W-1:0]    sw_ptr;
    logic [NUM_PORTS-1:0]                xbar_prev;
    logic [NUM_PORTS-1:0]                leaving;
    logic [NUM_PORTS-1:0][NUM_PORTS-1:0] vc_req;  // per output, by input.
    logic [NUM_PORTS-1:0][NUM_PORTS-1:0] sw_req;
    logic [NUM_PORTS-1:0][PORT_W-1:0]    vc_pick;
    logic [NUM_PORTS-1:0][PORT_W-1:0]    sw_pick;
    logic [NUM_PORTS-1:0][VC_W-1:0]      free_vc;
    logic [NUM_PORTS-1:0]                has_free;

    assign leaving = xbar_prev & ~req_crossbar;  // owner just left active.

    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                vc_req[o][p] = req_vc[p] && !vc_granted[p]
                               && switch_outport[p] == PORT_W'(o);
                sw_req[o][p] = req_switch[p] && !switch_granted[p]
                               && switch_outport[p] == PORT_W'(o);
            end
            vc_pick[o] = rr_pick(vc_req[o], vc_ptr[o]);
            sw_pick[o] = rr_pick(sw_req[o], sw_ptr[o]);
            has_free[o] = 1'b0;
            free_vc[o] = '0;
            for (int v = NUM_VCS - 1; v >= 0; v--) begin
                if (!vc_busy[o][v]) begin
                    has_free[o] = 1'b1;
                    free_vc[o] = VC_W'(v);  // lowest free wins.
                end
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            vc_busy <= '0;
            vc_ptr <= '0;
            sw_ptr <= '0;
            xbar_prev <= '0;
            vc_granted <= '0;
            vc_selection <= '0;
            switch_granted <= '0;
            out_owner <= '0;
            out_locked <= '0;
        end else begin
            xbar_prev <= req_crossbar;
            vc_granted <= '0;
            switch_granted <= '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (leaving[p]) begin
                    vc_busy[switch_outport[p]][vc_selection[p]] <= 1'b0;
                end
            end
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (out_locked[o] && leaving[out_owner[o]]) begin
                    out_locked[o] <= 1'b0;
                end
                if (|vc_req[o] && has_free[o]) begin
                    vc_busy[o][free_vc[o]] <= 1'b1;
                    vc_granted[vc_pick[o]] <= 1'b1;
                    vc_selection[vc_pick[o]] <= free_vc[o];
                    vc_ptr[o] <= next_port(vc_pick[o]);
                end
                if (!out_locked[o] && |sw_req[o]) begin
                    out_locked[o] <= 1'b1;
                    out_owner[o] <= sw_pick[o];
                    switch_granted[sw_pick[o]] <= 1'b1;
                    sw_ptr[o] <= next_port(sw_pick[o]);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/crossbar.sv
`timescale 1ns/1ps
`default_nettype none

module crossbar
    import noc_router_pkg::*;
(
    input  wire logic                              CLK,
    input  wire logic                              nRST,
    input  wire logic  [NUM_PORTS-1:0]             req_crossbar,
    input  wire logic  [NUM_PORTS-1:0]             fifo_empty,
    input  wire logic  [NUM_PORTS-1:0][VC_W-1:0]   final_vc,
    input  wire flit_u [NUM_PORTS-1:0]             rdata,
    input  wire logic  [NUM_PORTS-1:0][PORT_W-1:0] out_owner,
    input  wire logic  [NUM_PORTS-1:0]             out_locked,
    input  wire logic  [NUM_PORTS-1:0]             out_stall,
    output logic       [NUM_PORTS-1:0]             fifo_ren,
    output logic       [NUM_PORTS-1:0]             out_valid,
    output flit_u      [NUM_PORTS-1:0]             out_flit,
    output logic       [NUM_PORTS-1:0][VC_W-1:0]   out_vc
);

    logic [NUM_PORTS-1:0] moving;  // output takes a flit this cycle.

    always_comb begin
        fifo_ren = '0;
        for (int o = 0; o < NUM_PORTS; o++) begin
            moving[o] = out_locked[o] && !out_stall[o] && req_crossbar[out_owner[o]]
                        && !fifo_empty[out_owner[o]];
            if (moving[o]) begin
                fifo_ren[out_owner[o]] = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out_valid <= '0;
        end else begin
            out_valid <= moving;
        end
    end

    always_ff @(posedge CLK) begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (moving[o]) begin
                out_flit[o] <= rdata[out_owner[o]];
                out_vc[o] <= final_vc[out_owner[o]];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/noc_router.sv
`timescale 1ns/1ps
`default_nettype none

module noc_router
    import noc_router_pkg::*;
(
    input  wire logic                            CLK,
    input  wire logic                            nRST,
    input  wire logic  [NUM_PORTS-1:0]           in_wen,
    input  wire flit_u [NUM_PORTS-1:0]           in_flit,
    input  wire logic  [NUM_PORTS-1:0]           out_stall,
    output logic       [NUM_PORTS-1:0]           in_available,
    output logic       [NUM_PORTS-1:0]           out_valid,
    output flit_u      [NUM_PORTS-1:0]           out_flit,
    output logic       [NUM_PORTS-1:0][VC_W-1:0] out_vc
);

    flit_u [NUM_PORTS-1:0]             head_flit;
    logic  [NUM_PORTS-1:0]             fifo_empty;
    logic  [NUM_PORTS-1:0]             fifo_ren;
    logic  [NUM_PORTS-1:0]             req_routing;
    logic  [NUM_PORTS-1:0]             routing_granted;
    logic  [PORT_W-1:0]                routing_outport;
    logic  [NUM_PORTS-1:0]             req_vc;
    logic  [NUM_PORTS-1:0]             vc_granted;
    logic  [NUM_PORTS-1:0][VC_W-1:0]   vc_selection;
    logic  [NUM_PORTS-1:0]             req_switch;
    logic  [NUM_PORTS-1:0]             switch_granted;
    logic  [NUM_PORTS-1:0][PORT_W-1:0] switch_outport;
    logic  [NUM_PORTS-1:0][VC_W-1:0]   final_vc;
    logic  [NUM_PORTS-1:0]             req_crossbar;
    logic  [NUM_PORTS-1:0][PORT_W-1:0] out_owner;
    logic  [NUM_PORTS-1:0]             out_locked;

    input_buffers u_input_buffers (
        .CLK(CLK),
        .nRST(nRST),
        .in_wen(in_wen),
        .in_flit(in_flit),
        .fifo_ren(fifo_ren),
        .in_available(in_available),
        .head_flit(head_flit),
        .fifo_empty(fifo_empty),
        .req_routing(req_routing),
        .routing_granted(routing_granted),
        .routing_outport(routing_outport),
        .req_vc(req_vc),
        .vc_granted(vc_granted),
        .vc_selection(vc_selection),
        .req_switch(req_switch),
        .switch_granted(switch_granted),
        .switch_outport(switch_outport),
        .final_vc(final_vc),
        .req_crossbar(req_crossbar)
    );

    route_compute u_route_compute (
        .CLK(CLK),
        .nRST(nRST),
        .req_routing(req_routing),
        .head_flit(head_flit),
        .routing_granted(routing_granted),
        .routing_outport(routing_outport)
    );

    vc_switch_alloc u_vc_switch_alloc (
        .CLK(CLK),
        .nRST(nRST),
        .req_vc(req_vc),
        .req_switch(req_switch),
        .req_crossbar(req_crossbar),
        .switch_outport(switch_outport),
        .vc_granted(vc_granted),
        .vc_selection(vc_selection),
        .switch_granted(switch_granted),
        .out_owner(out_owner),
        .out_locked(out_locked)
    );

    crossbar u_crossbar (
        .CLK(CLK),
        .nRST(nRST),
        .req_crossbar(req_crossbar),
        .fifo_empty(fifo_empty),
        .final_vc(final_vc),
        .rdata(head_flit),
        .out_owner(out_owner),
        .out_locked(out_locked),
        .out_stall(out_stall),
        .fifo_ren(fifo_ren),
        .out_valid(out_valid),
        .out_flit(out_flit),
        .out_vc(out_vc)
    );

endmodule

`default_nettype wire

// File: verif/noc_router_checker.sv
`timescale 1ns/1ps
`default_nettype none

module noc_router_checker
    import noc_router_pkg::*;
(
    input wire logic                           CLK,
    input wire logic                           nRST,
    input wire logic  [NUM_PORTS-1:0]           out_valid,
    input wire flit_u [NUM_PORTS-1:0]           out_flit,
    input wire logic  [NUM_PORTS-1:0][VC_W-1:0] out_vc
);

    logic [NUM_PORTS-1:0][VC_W-1:0] pkt_vc;  // vc taken by the head.

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pkt_vc <= '0;
        end else begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (out_valid[o] && out_flit[o].head.kind == FLIT_HEAD) begin
                    pkt_vc[o] <= out_vc[o];
                end
            end
        end
    end

    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
        quiet_in_reset: assert property (@(posedge CLK) !nRST |-> !out_valid[o])
            else $error("output %0d valid during reset", o);
        vc_in_range: assert property (@(posedge CLK) disable iff (!nRST)
            out_valid[o] |-> !$isunknown(out_vc[o]) && 32'(out_vc[o]) < NUM_VCS)
            else $error("output %0d vc out of range", o);
        vc_held: assert property (@(posedge CLK) disable iff (!nRST)
            out_valid[o] && out_flit[o].body.kind == FLIT_BODY |-> out_vc[o] == pkt_vc[o])
            else $error("output %0d changed vc inside a packet", o);
    end

endmodule

`default_nettype wire

// File: verif/noc_router_tb.sv
`timescale 1ns/1ps
`default_nettype none

module noc_router_tb
    import noc_router_pkg::*;
();

    localparam int NUM_PKTS = 8;

    logic                  CLK;
    logic                  nRST;
    logic  [NUM_PORTS-1:0] in_wen;
    flit_u [NUM_PORTS-1:0] in_flit;
    logic  [NUM_PORTS-1:0] out_stall;

    // router outputs.
    wire logic  [NUM_PORTS-1:0]           in_available;
    wire logic  [NUM_PORTS-1:0]           out_valid;
    wire flit_u [NUM_PORTS-1:0]           out_flit;
    wire logic  [NUM_PORTS-1:0][VC_W-1:0] out_vc;

    // ======================================================================
    // packet table: input, dest x, dest y, length, expected output
    // ======================================================================
    int pkt_in   [NUM_PKTS] = '{1, 2, 3, 4, 0, 1, 0, 2};
    int pkt_x    [NUM_PKTS] = '{0, 4, 2, 2, 2, 3, 1, 2};
    int pkt_y    [NUM_PKTS] = '{2, 1, 4, 0, 2, 3, 0, 3};
    int pkt_len  [NUM_PKTS] = '{4, 3, 5, 2, 3, 4, 6, 4};
    int pkt_port [NUM_PKTS] = '{2, 1, 3, 4, 0, 1, 2, 3};

    flit_u                pkt_flits [NUM_PKTS][$];  // flits still expected.
    flit_u                send_q [NUM_PORTS][$];
    logic                 pkt_started [NUM_PKTS];
    int                   credit [NUM_PORTS];
    int                   avail_seen [NUM_PORTS];
    int                   flits_in [NUM_PORTS];
    int                   cur_pkt [NUM_PORTS];  // open packet per output.
    logic [NUM_PORTS-1:0] stall_prev;
    int                   rcv_pkts;
    int                   total_flits;
    logic [31:0]          rng;

    noc_router uut (
        .CLK(CLK),
        .nRST(nRST),
        .in_wen(in_wen),
        .in_flit(in_flit),
        .out_stall(out_stall),
        .in_available(in_available),
        .out_valid(out_valid),
        .out_flit(out_flit),
        .out_vc(out_vc)
    );

    bind noc_router noc_router_checker checker_i (
        .CLK(CLK),
        .nRST(nRST),
        .out_valid(out_valid),
        .out_flit(out_flit),
        .out_vc(out_vc)
    );

    always #2 CLK = ~CLK;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fail_run(input string why);
        if (why != "") begin
            $display("%s", why);
        end
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            fail_run("");
        end
    endtask

    task automatic build_packets();
        flit_u f;
        rng = 32'hcc76;
        total_flits = 0;
        for (int k = 0; k < NUM_PKTS; k++) begin
            f = '0;
            f.head.kind = FLIT_HEAD;
            f.head.dest_x = 3'(pkt_x[k]);
            f.head.dest_y = 3'(pkt_y[k]);
            f.head.length = PKT_LEN_W'(pkt_len[k]);
            f.head.spare = 16'(k);  // keeps every head unique.
            pkt_flits[k].push_back(f);
            send_q[pkt_in[k]].push_back(f);
            for (int b = 1; b < pkt_len[k]; b++) begin
                rng = next_random(rng);
                f.body.kind = FLIT_BODY;
                f.body.payload = rng[29:0];
                pkt_flits[k].push_back(f);
                send_q[pkt_in[k]].push_back(f);
            end
            total_flits += pkt_len[k];
            flits_in[pkt_in[k]] += pkt_len[k];
        end
    endtask

    // a head opens a packet, then its bodies must follow in order.
    task automatic take_flit(input int o, input flit_u f);
        int    hit;
        flit_u want;
        hit = cur_pkt[o];
        if (hit < 0) begin
            for (int k = 0; k < NUM_PKTS; k++) begin
                if (!pkt_started[k] && pkt_port[k] == o && pkt_flits[k][0] == f) begin
                    hit = k;
                end
            end
            if (hit < 0) begin
                fail_run($sformatf("output %0d sent flit %08h that starts no expected packet",
                                   o, f));
            end
            pkt_started[hit] = 1'b1;
            cur_pkt[o] = hit;
        end
        want = pkt_flits[hit].pop_front();
        check_value($sformatf("out_flit[%0d]", o), f, want);
        if (pkt_flits[hit].size() == 0) begin
            cur_pkt[o] = -1;
            rcv_pkts++;
        end
    endtask

    // ======================================================================
    // output monitor, sampled mid-cycle
    // ======================================================================
    always @(negedge CLK) begin
        if (nRST) begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                if (in_available[o] === 1'b1) begin
                    credit[o] += ROUTER_FIFO_THIRDS_RD;
                    avail_seen[o]++;
                end
                if (out_valid[o] === 1'b1) begin
                    if (stall_prev[o]) begin
                        fail_run($sformatf("output %0d sent a flit while stalled", o));
                    end
                    take_flit(o, out_flit[o]);
                end
                stall_prev[o] = out_stall[o];
            end
        end
    end

    initial begin
        int sent;
        CLK = 1'b0;
        nRST = 1'b0;
        in_wen = '0;
        in_flit = '0;
        stall_prev = '0;
        rcv_pkts = 0;
        sent = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            credit[p] = FIFO_DEPTH;
            avail_seen[p] = 0;
            flits_in[p] = 0;
            cur_pkt[p] = -1;
        end
        for (int k = 0; k < NUM_PKTS; k++) begin
            pkt_started[k] = 1'b0;
        end
        build_packets();
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;
        while (sent < total_flits) begin
            @(posedge CLK);
            #1;
            for (int p = 0; p < NUM_PORTS; p++) begin
                in_wen[p] = 1'b0;
                if (send_q[p].size() != 0 && credit[p] > 0) begin
                    in_flit[p] = send_q[p].pop_front();
                    in_wen[p] = 1'b1;
                    credit[p]--;
                    sent++;
                end
            end
        end
        @(posedge CLK);
        #1;
        in_wen = '0;
        wait (rcv_pkts == NUM_PKTS);
        repeat (4) @(posedge CLK);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("in_available[%0d] pulses", p), avail_seen[p],
                        flits_in[p] / ROUTER_FIFO_THIRDS_RD);
        end
        $display("all tests passed");
        $finish;
    end

    // back-pressure on the north output, once its first packet is under way.
    initial begin
        out_stall = '0;
        wait (nRST === 1'b1);
        @(negedge CLK);
        while (out_valid[PORT_NORTH] !== 1'b1) begin
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
        out_stall[PORT_NORTH] = 1'b1;
        repeat (20) @(posedge CLK);
        #1;
        out_stall[PORT_NORTH] = 1'b0;
    end

    initial begin
        #1;
        repeat (total_flits * 40 + 10) @(posedge CLK);
        fail_run("watchdog expired, the router outputs never drained");
    end

endmodule

`default_nettype wire

// File: verilog.f
rtl/noc_router_pkg.sv
rtl/flit_fifo.sv
rtl/input_buffers.sv
rtl/route_compute.sv
rtl/vc_switch_alloc.sv
rtl/crossbar.sv
rtl/noc_router.sv
verif/noc_router_checker.sv
verif/noc_router_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the router testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module noc_router_tb -Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vnoc_router_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -qx "tests failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
echo "simulation finished cleanly"
exit 0
